//--- logic/udp_pkg.sv
package udp_pkg;

   ////////////////////
   // Stream words
   ////////////////////

   typedef logic [35:0] word36_t;   // Host side, 32 data + 4 flags.
   typedef logic [18:0] line19_t;   // Line side, 16 data + 3 flags.

   localparam int WORD_DW = 32;
   localparam int LINE_DW = 16;

   // Flag offsets above the data field.
   localparam int SOF_BIT  = 0;
   localparam int EOF_BIT  = 1;
   localparam int HALF_BIT = LINE_DW + 2;   // Only upper byte valid.
   localparam int OCC_LSB  = WORD_DW + 2;   // Two bits, 0 means all four.

   ////////////////////
   // Settings bus
   ////////////////////

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   localparam int SET_HDR0 = 0;   // Header lines 0 and 1.
   localparam int SET_HDR1 = 1;   // Header lines 2 and 3.
   localparam int SET_CTRL = 2;   // Bit 0 enables the header.

   localparam int HDR_LINES     = 4;
   localparam int TX_FIFO_DEPTH = 16;
   localparam int RX_FIFO_DEPTH = 32;

   typedef enum logic [1:0] {IDLE, HEADER, BODY} tx_state_t;

endpackage

//--- logic/fifo_short.sv
`timescale 1ns/1ps

module fifo_short #(
   parameter int WIDTH = 19,
   parameter int DEPTH = 16
) (
   input  logic             clk,
   input  logic             arst_n_i,
   input  logic             clear_i,
   input  logic [WIDTH-1:0] data_i,
   input  logic             src_rdy_i,
   output logic             dst_rdy_o,
   output logic [WIDTH-1:0] data_o,
   output logic             src_rdy_o,
   input  logic             dst_rdy_i
);

   logic [WIDTH-1:0]             mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]     wr_ptr;
   logic [$clog2(DEPTH)-1:0]     rd_ptr;
   logic [$clog2(DEPTH+1)-1:0]   count;
   logic                         wr_en;
   logic                         rd_en;

   assign dst_rdy_o = (count != ($clog2(DEPTH+1))'(DEPTH));
   assign src_rdy_o = (count != '0);
   assign wr_en     = src_rdy_i && dst_rdy_o;
   assign rd_en     = src_rdy_o && dst_rdy_i;
   assign data_o    = mem[rd_ptr];   // Head word is already registered.

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         if (wr_en && !rd_en)
            count <= count + 1'b1;
         else if (rd_en && !wr_en)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) mem[wr_ptr] <= data_i;
   end

   // Pointer distance tracks the fill level.
   a_ptr_count: assert property (@(posedge clk) disable iff (!arst_n_i)
      (wr_ptr - rd_ptr) == count[$clog2(DEPTH)-1:0]);

   // Head word holds while the reader stalls.
   a_hold_head: assert property (@(posedge clk) disable iff (!arst_n_i)
      src_rdy_o && !dst_rdy_i && !clear_i |=> src_rdy_o && $stable(data_o));

endmodule

//--- logic/fifo36_to_fifo19.sv
`timescale 1ns/1ps

module fifo36_to_fifo19 (
   input  logic             clk,
   input  logic             arst_n_i,
   input  logic             clear_i,
   input  udp_pkg::word36_t f36_data_i,
   input  logic             f36_src_rdy_i,
   output logic             f36_dst_rdy_o,
   output udp_pkg::line19_t f19_data_o,
   output logic             f19_src_rdy_o,
   input  logic             f19_dst_rdy_i
);

   import udp_pkg::*;

   word36_t    word_q;
   logic       full_q;
   logic       phase_q;    // Low while the upper half is out.
   logic [1:0] occ;
   logic       is_eof;
   logic       short_last;
   logic       last_line;
   logic       take;
   logic       give;

   assign occ        = word_q[OCC_LSB +: 2];
   assign is_eof     = word_q[WORD_DW + EOF_BIT];
   assign short_last = is_eof && (occ == 2'd1 || occ == 2'd2);   // One line only.
   assign last_line  = phase_q || short_last;

   assign f36_dst_rdy_o = !full_q;
   assign f19_src_rdy_o = full_q;
   assign take = f36_src_rdy_i && f36_dst_rdy_o;
   assign give = f19_src_rdy_o && f19_dst_rdy_i;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         full_q  <= 1'b0;
         phase_q <= 1'b0;
      end else if (clear_i) begin
         full_q  <= 1'b0;
         phase_q <= 1'b0;
      end else if (take) begin
         full_q  <= 1'b1;
         phase_q <= 1'b0;
      end else if (give) begin
         full_q  <= !last_line;
         phase_q <= !last_line;
      end
   end

   always_ff @(posedge clk) begin
      if (take) word_q <= f36_data_i;
   end

   ////////////////////
   // Line select
   ////////////////////

   always_comb begin
      f19_data_o = '0;
      if (!phase_q) begin
         f19_data_o[LINE_DW-1:0]        = word_q[WORD_DW-1:LINE_DW];
         f19_data_o[LINE_DW + SOF_BIT]  = word_q[WORD_DW + SOF_BIT];
         f19_data_o[LINE_DW + EOF_BIT]  = short_last;
         f19_data_o[HALF_BIT]           = is_eof && (occ == 2'd1);
      end else begin
         f19_data_o[LINE_DW-1:0]        = word_q[LINE_DW-1:0];
         f19_data_o[LINE_DW + EOF_BIT]  = is_eof;
         f19_data_o[HALF_BIT]           = is_eof && (occ == 2'd3);
      end
   end

endmodule

//--- logic/fifo19_to_fifo36.sv
`timescale 1ns/1ps

module fifo19_to_fifo36 (
   input  logic             clk,
   input  logic             arst_n_i,
   input  logic             clear_i,
   input  udp_pkg::line19_t f19_data_i,
   input  logic             f19_src_rdy_i,
   output logic             f19_dst_rdy_o,
   output udp_pkg::word36_t f36_data_o,
   output logic             f36_src_rdy_o,
   input  logic             f36_dst_rdy_i
);

   import udp_pkg::*;

   line19_t hi_q;        // First line of the pair.
   word36_t word_q;
   word36_t word_d;
   logic    have_hi_q;
   logic    valid_q;
   logic    in_eof;
   logic    in_half;
   logic    take;
   logic    give;
   logic    emit;

   assign in_eof  = f19_data_i[LINE_DW + EOF_BIT];
   assign in_half = f19_data_i[HALF_BIT];

   assign f19_dst_rdy_o = !valid_q;
   assign f36_src_rdy_o = valid_q;
   assign f36_data_o    = word_q;
   assign take = f19_src_rdy_i && f19_dst_rdy_o;
   assign give = f36_src_rdy_o && f36_dst_rdy_i;
   assign emit = take && (have_hi_q || in_eof);

   always_comb begin
      word_d = '0;
      if (!have_hi_q) begin
         // Frame ends on an upper half.
         word_d[WORD_DW-1:LINE_DW]   = f19_data_i[LINE_DW-1:0];
         word_d[WORD_DW + SOF_BIT]   = f19_data_i[LINE_DW + SOF_BIT];
         word_d[WORD_DW + EOF_BIT]   = 1'b1;
         word_d[OCC_LSB +: 2]        = in_half ? 2'd1 : 2'd2;
      end else begin
         word_d[WORD_DW-1:LINE_DW]   = hi_q[LINE_DW-1:0];
         word_d[LINE_DW-1:0]         = f19_data_i[LINE_DW-1:0];
         word_d[WORD_DW + SOF_BIT]   = hi_q[LINE_DW + SOF_BIT];
         word_d[WORD_DW + EOF_BIT]   = in_eof;
         word_d[OCC_LSB +: 2]        = (in_eof && in_half) ? 2'd3 : 2'd0;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         have_hi_q <= 1'b0;
         valid_q   <= 1'b0;
      end else if (clear_i) begin
         have_hi_q <= 1'b0;
         valid_q   <= 1'b0;
      end else begin
         if (give) valid_q <= 1'b0;
         if (emit) valid_q <= 1'b1;
         if (take) have_hi_q <= !emit;
      end
   end

   always_ff @(posedge clk) begin
      if (take && !have_hi_q) hi_q <= f19_data_i;
      if (emit) word_q <= word_d;
   end

   // Frames must start on a word boundary.
   a_sof_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
      take && have_hi_q |-> !f19_data_i[LINE_DW + SOF_BIT]);

endmodule

//--- logic/fifo19_rxrealign.sv
`timescale 1ns/1ps

module fifo19_rxrealign (
   input  logic             clk,
   input  logic             arst_n_i,
   input  logic             clear_i,
   input  udp_pkg::line19_t datain,
   input  logic             src_rdy_i,
   output logic             dst_rdy_o,
   output udp_pkg::line19_t dataout,
   output logic             src_rdy_o,
   input  logic             dst_rdy_i
);

   import udp_pkg::*;

   line19_t out_q;
   line19_t next_line;
   logic    out_valid_q;
   logic    pad_sent_q;   // Pad line already out for this frame.
   logic    pad_now;
   logic    load;
   logic    give;

   assign pad_now   = datain[LINE_DW + SOF_BIT] && !pad_sent_q;
   assign load      = src_rdy_i && !out_valid_q;
   assign dst_rdy_o = !out_valid_q && !pad_now;   // Input held behind the pad.
   assign src_rdy_o = out_valid_q;
   assign dataout   = out_q;
   assign give      = src_rdy_o && dst_rdy_i;

   always_comb begin
      next_line = datain;
      next_line[LINE_DW + SOF_BIT] = 1'b0;
      if (pad_now) begin
         next_line = '0;
         next_line[LINE_DW + SOF_BIT] = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         out_valid_q <= 1'b0;
         pad_sent_q  <= 1'b0;
      end else if (clear_i) begin
         out_valid_q <= 1'b0;
         pad_sent_q  <= 1'b0;
      end else begin
         if (give) out_valid_q <= 1'b0;
         if (load) begin
            out_valid_q <= 1'b1;
            if (pad_now)
               pad_sent_q <= 1'b1;
            else if (datain[LINE_DW + EOF_BIT])
               pad_sent_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) out_q <= next_line;
   end

endmodule

//--- logic/prot_eng_tx.sv
`timescale 1ns/1ps

module prot_eng_tx #(
   parameter int BASE = 0
) (
   input  logic               clk,
   input  logic               arst_n_i,
   input  logic               clear_i,
   input  logic               set_stb_i,
   input  udp_pkg::set_addr_t set_addr_i,
   input  udp_pkg::set_data_t set_data_i,
   input  udp_pkg::line19_t   data_i,
   input  logic               src_rdy_i,
   output logic               dst_rdy_o,
   output udp_pkg::line19_t   data_o,
   output logic               src_rdy_o,
   input  logic               dst_rdy_i
);

   import udp_pkg::*;

   set_data_t                    hdr0_q;
   set_data_t                    hdr1_q;
   logic                         en_q;
   logic [HDR_LINES*LINE_DW-1:0] hdr_all;
   line19_t                      hdr_line;
   line19_t                      body_q;
   line19_t                      body_d;
   logic                         body_valid_q;
   logic                         frame_hdr_q;   // Current frame got a header.
   logic [$clog2(HDR_LINES)-1:0] cnt_q;
   tx_state_t                    state_q;
   logic                         in_sof;
   logic                         take;
   logic                         give;

   ////////////////////
   // Settings
   ////////////////////

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hdr0_q <= '0;
         hdr1_q <= '0;
         en_q   <= 1'b0;
      end else if (set_stb_i) begin
         if (set_addr_i == set_addr_t'(BASE + SET_HDR0)) hdr0_q <= set_data_i;
         if (set_addr_i == set_addr_t'(BASE + SET_HDR1)) hdr1_q <= set_data_i;
         if (set_addr_i == set_addr_t'(BASE + SET_CTRL)) en_q <= set_data_i[0];
      end
   end

   ////////////////////
   // Framing
   ////////////////////

   assign in_sof    = data_i[LINE_DW + SOF_BIT];
   assign hdr_all   = {hdr0_q, hdr1_q};   // Line 0 in the top half.
   assign dst_rdy_o = (state_q == BODY) && !body_valid_q;
   assign src_rdy_o = (state_q == HEADER) || body_valid_q;
   assign take      = src_rdy_i && dst_rdy_o;
   assign give      = src_rdy_o && dst_rdy_i;

   always_comb begin
      hdr_line = '0;
      hdr_line[LINE_DW-1:0] = hdr_all[(HDR_LINES - 1 - cnt_q) * LINE_DW +: LINE_DW];
      hdr_line[LINE_DW + SOF_BIT] = (cnt_q == '0);
      body_d = data_i;
      if (frame_hdr_q) body_d[LINE_DW + SOF_BIT] = 1'b0;
      data_o = (state_q == HEADER) ? hdr_line : body_q;
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q      <= IDLE;
         cnt_q        <= '0;
         frame_hdr_q  <= 1'b0;
         body_valid_q <= 1'b0;
      end else if (clear_i) begin
         state_q      <= IDLE;
         cnt_q        <= '0;
         frame_hdr_q  <= 1'b0;
         body_valid_q <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (src_rdy_i) begin   // Enable sampled here only.
                  frame_hdr_q <= en_q && in_sof;
                  cnt_q       <= '0;
                  state_q     <= (en_q && in_sof) ? HEADER : BODY;
               end
            end
            HEADER: begin
               if (give) begin
                  cnt_q <= cnt_q + 1'b1;
                  if (cnt_q == ($clog2(HDR_LINES))'(HDR_LINES - 1)) state_q <= BODY;
               end
            end
            BODY: begin
               if (give) begin
                  body_valid_q <= 1'b0;
                  if (body_q[LINE_DW + EOF_BIT]) state_q <= IDLE;
               end else if (take) begin
                  body_valid_q <= 1'b1;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) body_q <= body_d;
   end

   // Last body line must leave before returning to idle.
   a_idle_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
      state_q == IDLE |-> !src_rdy_o);

endmodule

//--- logic/udp_wrapper.sv
`timescale 1ns/1ps

module udp_wrapper #(
   parameter int BASE = 0
) (
   input  logic               clk,
   input  logic               arst_n_i,
   input  logic               clear_i,
   input  logic               set_stb_i,
   input  udp_pkg::set_addr_t set_addr_i,
   input  udp_pkg::set_data_t set_data_i,
   input  udp_pkg::word36_t   tx_f36_data_i,
   input  logic               tx_f36_src_rdy_i,
   output logic               tx_f36_dst_rdy_o,
   output udp_pkg::line19_t   tx_f19_data_o,
   output logic               tx_f19_src_rdy_o,
   input  logic               tx_f19_dst_rdy_i,
   input  udp_pkg::line19_t   rx_f19_data_i,
   input  logic               rx_f19_src_rdy_i,
   output logic               rx_f19_dst_rdy_o,
   output udp_pkg::word36_t   rx_f36_data_o,
   output logic               rx_f36_src_rdy_o,
   input  logic               rx_f36_dst_rdy_i
);

   import udp_pkg::*;

   line19_t tx_int1_data, tx_int2_data;
   logic    tx_int1_src_rdy, tx_int1_dst_rdy;
   logic    tx_int2_src_rdy, tx_int2_dst_rdy;
   line19_t rx_int1_data, rx_int2_data;
   logic    rx_int1_src_rdy, rx_int1_dst_rdy;
   logic    rx_int2_src_rdy, rx_int2_dst_rdy;

   ////////////////////
   // Transmit chain
   ////////////////////

   fifo36_to_fifo19 tx_conv (
      .clk(clk), .arst_n_i(arst_n_i), .clear_i(clear_i),
      .f36_data_i(tx_f36_data_i), .f36_src_rdy_i(tx_f36_src_rdy_i),
      .f36_dst_rdy_o(tx_f36_dst_rdy_o),
      .f19_data_o(tx_int1_data), .f19_src_rdy_o(tx_int1_src_rdy),
      .f19_dst_rdy_i(tx_int1_dst_rdy));

   fifo_short #(.WIDTH($bits(line19_t)), .DEPTH(TX_FIFO_DEPTH)) tx_fifo (
      .clk(clk), .arst_n_i(arst_n_i), .clear_i(clear_i),
      .data_i(tx_int1_data), .src_rdy_i(tx_int1_src_rdy), .dst_rdy_o(tx_int1_dst_rdy),
      .data_o(tx_int2_data), .src_rdy_o(tx_int2_src_rdy), .dst_rdy_i(tx_int2_dst_rdy));

   prot_eng_tx #(.BASE(BASE)) tx_prot (
      .clk(clk), .arst_n_i(arst_n_i), .clear_i(clear_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .data_i(tx_int2_data), .src_rdy_i(tx_int2_src_rdy), .dst_rdy_o(tx_int2_dst_rdy),
      .data_o(tx_f19_data_o), .src_rdy_o(tx_f19_src_rdy_o), .dst_rdy_i(tx_f19_dst_rdy_i));

   ////////////////////
   // Receive chain
   ////////////////////

   fifo19_rxrealign rx_realign (
      .clk(clk), .arst_n_i(arst_n_i), .clear_i(clear_i),
      .datain(rx_f19_data_i), .src_rdy_i(rx_f19_src_rdy_i), .dst_rdy_o(rx_f19_dst_rdy_o),
      .dataout(rx_int1_data), .src_rdy_o(rx_int1_src_rdy), .dst_rdy_i(rx_int1_dst_rdy));

   fifo_short #(.WIDTH($bits(line19_t)), .DEPTH(RX_FIFO_DEPTH)) rx_fifo (
      .clk(clk), .arst_n_i(arst_n_i), .clear_i(clear_i),
      .data_i(rx_int1_data), .src_rdy_i(rx_int1_src_rdy), .dst_rdy_o(rx_int1_dst_rdy),
      .data_o(rx_int2_data), .src_rdy_o(rx_int2_src_rdy), .dst_rdy_i(rx_int2_dst_rdy));

   fifo19_to_fifo36 rx_conv (
      .clk(clk), .arst_n_i(arst_n_i), .clear_i(clear_i),
      .f19_data_i(rx_int2_data), .f19_src_rdy_i(rx_int2_src_rdy),
      .f19_dst_rdy_o(rx_int2_dst_rdy),
      .f36_data_o(rx_f36_data_o), .f36_src_rdy_o(rx_f36_src_rdy_o),
      .f36_dst_rdy_i(rx_f36_dst_rdy_i));

endmodule

//--- tests/udp_wrapper_tb_tasks.svh
////////////////////
// Bus and control
////////////////////

function automatic logic random_stall();
   return stall_en && (($random(seed) & 3) == 0);
endfunction

task automatic write_setting(input set_addr_t addr, input set_data_t data);
   @(posedge clk);
   #1;
   set_stb_i  = 1'b1;
   set_addr_i = addr;
   set_data_i = data;
   @(posedge clk);
   #1;
   set_stb_i = 1'b0;
endtask

task automatic pulse_clear();
   @(posedge clk);
   #1;
   clear_i = 1'b1;
   @(posedge clk);
   #1;
   clear_i = 1'b0;
endtask

task automatic wait_drained();
   while (tx_in_q.size() != 0 || rx_in_q.size() != 0 ||
          tx_exp_q.size() != 0 || rx_exp_q.size() != 0) begin
      @(posedge clk);
   end
   @(posedge clk);   // Last transfer lands on this edge.
endtask

task automatic report_counts();
   $display("Errors: %0d, transmit lines received: %0d, receive words received: %0d",
            errors, tx_lines_seen, rx_words_seen);
endtask

////////////////////
// Drivers
////////////////////

task automatic drive_tx_words();
   logic fire;
   forever begin
      @(negedge clk);
      fire = tx_f36_src_rdy_i && tx_f36_dst_rdy_o;
      @(posedge clk);
      #1;
      if (fire) begin
         void'(tx_in_q.pop_front());
         tx_f36_src_rdy_i = 1'b0;
      end
      if (!tx_f36_src_rdy_i && tx_in_q.size() != 0 && !random_stall()) begin
         tx_f36_data_i    = tx_in_q[0];
         tx_f36_src_rdy_i = 1'b1;
      end
   end
endtask

task automatic drive_rx_lines();
   logic fire;
   forever begin
      @(negedge clk);
      fire = rx_f19_src_rdy_i && rx_f19_dst_rdy_o;
      @(posedge clk);
      #1;
      if (fire) begin
         void'(rx_in_q.pop_front());
         rx_f19_src_rdy_i = 1'b0;
      end
      if (!rx_f19_src_rdy_i && rx_in_q.size() != 0 && !random_stall()) begin
         rx_f19_data_i    = rx_in_q[0];
         rx_f19_src_rdy_i = 1'b1;
      end
   end
endtask

////////////////////
// Monitors
////////////////////

task automatic check_tx_lines();
   line19_t want;
   forever begin
      @(negedge clk);   // Handshake is stable here.
      if (tx_f19_src_rdy_o && tx_f19_dst_rdy_i) begin
         tx_lines_seen++;
         if (tx_exp_q.size() == 0) begin
            errors++;
            $display("Transmit line %h came out with nothing left to expect, at %0t",
                     tx_f19_data_o, $time);
         end else begin
            want = tx_exp_q.pop_front();
            if (tx_f19_data_o !== want) begin
               errors++;
               $display("CHECK FAILED at %0t: transmit line %h, expected %h",
                        $time, tx_f19_data_o, want);
            end
         end
      end
      @(posedge clk);
      #1;
      tx_f19_dst_rdy_i = !random_stall();
   end
endtask

task automatic check_rx_words();
   word36_t want;
   forever begin
      @(negedge clk);
      if (rx_f36_src_rdy_o && rx_f36_dst_rdy_i) begin
         rx_words_seen++;
         if (rx_exp_q.size() == 0) begin
            errors++;
            $display("Receive word %h came out with nothing left to expect, at %0t",
                     rx_f36_data_o, $time);
         end else begin
            want = rx_exp_q.pop_front();
            if (rx_f36_data_o !== want) begin
               errors++;
               $display("CHECK FAILED at %0t: receive word %h, expected %h",
                        $time, rx_f36_data_o, want);
            end
         end
      end
      @(posedge clk);
      #1;
      rx_f36_dst_rdy_i = !random_stall();
   end
endtask

////////////////////
// Vector walk
////////////////////

task automatic run_vectors();
   logic [47:0] v;
   for (int i = 0; i < n_vec; i++) begin
      v = vec[i];
      case (v[47:44])
         4'h1: write_setting(v[39:32], v[31:0]);
         4'h2: tx_in_q.push_back(v[35:0]);
         4'h3: tx_exp_q.push_back(v[18:0]);
         4'h4: rx_in_q.push_back(v[18:0]);
         4'h5: rx_exp_q.push_back(v[35:0]);
         4'h6: wait_drained();
         4'h7: pulse_clear();
         4'h8: stall_en = v[0];
         default: begin
            errors++;
            $display("Vector entry %0d has an unknown kind: %h", i, v);
         end
      endcase
   end
   wait_drained();
endtask

//--- tests/udp_wrapper_tb.sv
`timescale 1ns/1ps

module udp_wrapper_tb;

   import udp_pkg::*;

   logic        clk;
   logic        arst_n_i;
   logic        clear_i;
   logic        set_stb_i;
   set_addr_t   set_addr_i;
   set_data_t   set_data_i;
   word36_t     tx_f36_data_i;
   logic        tx_f36_src_rdy_i;
   logic        tx_f36_dst_rdy_o;
   line19_t     tx_f19_data_o;
   logic        tx_f19_src_rdy_o;
   logic        tx_f19_dst_rdy_i;
   line19_t     rx_f19_data_i;
   logic        rx_f19_src_rdy_i;
   logic        rx_f19_dst_rdy_o;
   word36_t     rx_f36_data_o;
   logic        rx_f36_src_rdy_o;
   logic        rx_f36_dst_rdy_i;

   logic [47:0] vec [256];   // Kind nibble over payload.
   int          n_vec;
   int          cycle_limit;
   int          cycle_cnt = 0;
   int          errors;
   int          tx_lines_seen;
   int          rx_words_seen;
   integer      seed = 32'h1764;
   logic        stall_en;

   word36_t     tx_in_q[$];
   line19_t     tx_exp_q[$];
   line19_t     rx_in_q[$];
   word36_t     rx_exp_q[$];

   udp_wrapper #(.BASE(8)) dut0 (
      .clk(clk), .arst_n_i(arst_n_i), .clear_i(clear_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .tx_f36_data_i(tx_f36_data_i), .tx_f36_src_rdy_i(tx_f36_src_rdy_i),
      .tx_f36_dst_rdy_o(tx_f36_dst_rdy_o),
      .tx_f19_data_o(tx_f19_data_o), .tx_f19_src_rdy_o(tx_f19_src_rdy_o),
      .tx_f19_dst_rdy_i(tx_f19_dst_rdy_i),
      .rx_f19_data_i(rx_f19_data_i), .rx_f19_src_rdy_i(rx_f19_src_rdy_i),
      .rx_f19_dst_rdy_o(rx_f19_dst_rdy_o),
      .rx_f36_data_o(rx_f36_data_o), .rx_f36_src_rdy_o(rx_f36_src_rdy_o),
      .rx_f36_dst_rdy_i(rx_f36_dst_rdy_i));

   `include "udp_wrapper_tb_tasks.svh"

   ////////////////////
   // Clock and timeout
   ////////////////////

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("Run timed out after %0d cycles without all expected words",
                  cycle_cnt);
         report_counts();
         $display("=== FAIL ===");
         $finish;
      end
   end

   initial drive_tx_words();
   initial drive_rx_lines();
   initial check_tx_lines();
   initial check_rx_words();

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      arst_n_i         = 1'b0;
      clear_i          = 1'b0;
      set_stb_i        = 1'b0;
      set_addr_i       = '0;
      set_data_i       = '0;
      tx_f36_data_i    = '0;
      tx_f36_src_rdy_i = 1'b0;
      tx_f19_dst_rdy_i = 1'b1;
      rx_f19_data_i    = '0;
      rx_f19_src_rdy_i = 1'b0;
      rx_f36_dst_rdy_i = 1'b1;
      stall_en         = 1'b0;
      errors           = 0;
      tx_lines_seen    = 0;
      rx_words_seen    = 0;
      cycle_limit      = 0;

      $readmemh("tests/udp_wrapper_vectors.txt", vec);
      n_vec = 0;
      while (n_vec < $size(vec) && vec[n_vec][47:44] !== 4'hF)
         n_vec++;
      if (n_vec == $size(vec)) begin
         errors++;
         $display("Vector file has no end marker, nothing was run");
         n_vec = 0;
      end
      cycle_limit = 40 * n_vec + 200;

      repeat (2) @(posedge clk);
      #1;
      arst_n_i = 1'b1;

      run_vectors();
      repeat (20) @(posedge clk);   // Quiet window for stray output.

      report_counts();
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- udp_wrapper.f
+incdir+tests
logic/udp_pkg.sv
logic/fifo_short.sv
logic/fifo36_to_fifo19.sv
logic/fifo19_to_fifo36.sv
logic/fifo19_rxrealign.sv
logic/prot_eng_tx.sv
logic/udp_wrapper.sv
tests/udp_wrapper_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = udp_wrapper_tb
FILELIST = udp_wrapper.f
PASS_MSG = === PASS ===
BIN      = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- tests/udp_wrapper_vectors.txt
// One 48-bit entry per value, top hex digit is the kind and the rest its payload.
// 1 setting {addr,data}, 2 tx word, 3 tx line, 4 rx line, 5 rx word, 6 drain,
// 7 clear pulse, 8 stall mode, F end.
800000000000
100845000034 100911223344 100A00000001
// Frame A, last word full.
200101020304 200205060708
300000014500 300000000034 300000001122 300000003344
300000000102 300000000304 300000000506 300000020708
// Two lines in, pad makes three.
400000017172 400000027374
500100007172 500A73740000
600000000000
// Random stalls from here on.
800000000001
// Frame B, occupancy 3.
200111121314 200E15161700
300000014500 300000000034 300000001122 300000003344
300000001112 300000001314 300000001516 300000061700
// Frame C, one word with occupancy 2.
200B21220000
300000014500 300000000034 300000001122 300000003344
300000022122
// Frame D, occupancy 1.
200131323334 200635000000
300000014500 300000000034 300000001122 300000003344
300000003132 300000003334 300000063500
400000018182 400000008384 400000028586
500100008182 500283848586
400000019192 400000009394 400000069500
500100009192 500E93949500
600000000000
// Header off, then a write outside the block.
100A00000000 100200000001
200341424344
300000014142 300000024344
200F51525300
300000015152 300000065300
40000001A1A2 40000006A300
50010000A1A2 5006A3000000
600000000000
// Header on again, then a clear.
100A00000001 700000000000
200161626364 200A65660000
300000014500 300000000034 300000001122 300000003344
300000006162 300000006364 300000026566
40000003B1B2
50030000B1B2
600000000000
F00000000000
